/* video_sync.f */
design/video_timing_pkg.sv
design/video_int_pkg.sv
design/hsync_gen.sv
design/vsync_gen.sv
design/int_ctrl.sv
design/video_sync_top.sv
test/clock_gen.sv
test/video_sync_sva.sv
test/video_sync_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the video timing testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f video_sync.f --top-module video_sync_tb \
	-o video_sync_sim || exit 1
out=$(./obj_dir/video_sync_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "TEST PASSED" && echo "simulation ok" || { echo "simulation bad"; exit 1; }

/* test/video_sync_tb.sv */
`timescale 1ns/100ps

module video_sync_tb;

	import video_timing_pkg::*;
	import video_int_pkg::*;

	// shrunk raster, one frame is 40 x 48 clocks
	localparam logic [15:0] SIM_H_PERIOD  = 16'd40;
	localparam logic [15:0] SIM_HSYNC_BEG = 16'd4;
	localparam logic [15:0] SIM_HSYNC_END = 16'd10;
	localparam logic [15:0] SIM_HBLNK_END = 16'd16;
	localparam logic [15:0] SIM_HINT_BEG  = 16'd2;
	localparam logic [15:0] SIM_V_PERIOD  = 16'd48;
	localparam logic [15:0] SIM_VBLNK_END = 16'd8;
	localparam logic [15:0] SIM_VSYNC_BEG = 16'd2;
	localparam logic [15:0] SIM_VSYNC_END = 16'd4;
	localparam logic [15:0] SIM_VPIX_BEG  = 16'd12;
	localparam logic [15:0] SIM_VPIX_END  = 16'd40;
	localparam logic [15:0] SIM_INT_LINE  = 16'd0;
	localparam logic [15:0] SIM_S_RELOAD  = 16'd20;
	localparam logic [15:0] SIM_INT_LEN   = 16'd8;
	localparam int FRAME_CLOCKS = 40 * 48;
	localparam int ROWS  = 6;
	localparam int NEVER = 32'h7fff_ffff; // ready stays low

	typedef struct packed {
		int          frame_no; // frame whose INT this row answers
		int          delay;    // clocks of int_valid before int_ready
		int_result_t exp_res;
	} stim_row_t;

	logic clk, reset, int_valid, int_ready;
	line_strobe_t  line;
	frame_strobe_t frame;
	int_result_t   result;

	logic [15:0]   m_h, m_v, m_win; // model counters
	int            m_frame_no;
	line_strobe_t  exp_line;
	frame_strobe_t exp_frame;
	int_result_t   exp_result;
	logic          exp_valid;
	logic          m_started = 1'b0; // model has seen a clock
	logic          m_active = 1'b0;  // out of reset
	logic          hs_seen = 1'b0;
	int            hs_gap = 0;
	integer        seed = 32'h1532_eb30;
	stim_row_t     rows [ROWS];

	clock_gen u_clk (.clk(clk), .reset(reset));

	video_sync_top #(
		.h_period(SIM_H_PERIOD), .hsync_beg(SIM_HSYNC_BEG), .hsync_end(SIM_HSYNC_END),
		.hblnk_end(SIM_HBLNK_END), .hint_beg(SIM_HINT_BEG), .v_period(SIM_V_PERIOD),
		.vblnk_end(SIM_VBLNK_END), .vsync_beg(SIM_VSYNC_BEG), .vsync_end(SIM_VSYNC_END),
		.vpix_beg(SIM_VPIX_BEG), .vpix_end(SIM_VPIX_END), .int_line(SIM_INT_LINE),
		.s_reload_line(SIM_S_RELOAD), .int_len(SIM_INT_LEN)
	) DUT (
		.clk(clk), .reset(reset), .line(line), .frame(frame),
		.int_valid(int_valid), .int_ready(int_ready), .result(result)
	);

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_line(input line_strobe_t got, input line_strobe_t exp);
		if (got !== exp)
			fail_run($sformatf("[ERROR] %0t: line strobes %b, expected %b", $time, got, exp));
	endtask

	task automatic check_frame(input frame_strobe_t got, input frame_strobe_t exp);
		if (got !== exp)
			fail_run($sformatf("[ERROR] %0t: frame strobes %b, expected %b", $time, got, exp));
	endtask

	task automatic check_int(input int_result_t got_res, input int_result_t exp_res,
		input logic got_valid, input logic exp_valid);
		if (got_res !== exp_res || got_valid !== exp_valid)
			fail_run($sformatf("[ERROR] %0t: int_valid %b result %b, expected %b and %b",
				$time, got_valid, got_res, exp_valid, exp_res));
	endtask

	// reference model, each value predicted from the previous cycle
	always @(posedge clk)
	begin
		m_started = 1'b1;
		m_active  = !reset;
		if (reset)
		begin
			m_h = 16'd0;
			m_v = 16'd0;
			m_win = 16'd0;
			m_frame_no = 0;
			exp_line = '0;
			exp_frame = '0;
			exp_result = '0;
			exp_valid = 1'b0;
		end
		else
		begin
			// request held until ready or INT_LEN clocks
			exp_result.taken  = exp_valid & int_ready;
			exp_result.missed = exp_valid & ~int_ready & (m_win == SIM_INT_LEN - 16'd1);
			if (exp_valid)
			begin
				if (int_ready || m_win == SIM_INT_LEN - 16'd1)
					exp_valid = 1'b0;
				else
					m_win = m_win + 16'd1;
			end
			else if (exp_frame.int_start)
			begin
				exp_valid = 1'b1; // one clock after int_start
				m_win = 16'd0;
			end

			// frame levels from last cycle's line strobes
			exp_frame.int_start = exp_line.hint_start && (m_v == SIM_INT_LINE);
			if (exp_line.hsync_start)
			begin
				exp_frame.vblank = (m_v < SIM_VBLNK_END);
				exp_frame.vpix   = (m_v >= SIM_VPIX_BEG) && (m_v < SIM_VPIX_END);
				if (m_v == SIM_VSYNC_BEG)
					exp_frame.vsync = 1'b1;
			end
			if (exp_line.line_start)
			begin
				if (m_v == SIM_VSYNC_END)
					exp_frame.vsync = 1'b0; // ends on line_start, not hsync_start
				exp_frame.pre_vline = (m_v == SIM_VBLNK_END);
				exp_frame.s_reload  = (m_v == SIM_S_RELOAD);
			end
			if (exp_line.hsync_start)
			begin
				if (m_v == SIM_V_PERIOD - 16'd1)
				begin
					m_v = 16'd0;
					m_frame_no++;
				end
				else
					m_v = m_v + 16'd1;
			end

			// line strobes from last hcount
			exp_line.hsync_start = (m_h == SIM_HSYNC_BEG);
			exp_line.line_start  = (m_h == SIM_HSYNC_END);
			exp_line.hint_start  = (m_h == SIM_HINT_BEG);
			exp_line.hblank      = (m_h < SIM_HBLNK_END);
			exp_line.hsync       = (m_h >= SIM_HSYNC_BEG) && (m_h < SIM_HSYNC_END);
			m_h = (m_h == SIM_H_PERIOD - 16'd1) ? 16'd0 : m_h + 16'd1;
		end
	end

	// every cycle compared on the falling edge
	always @(negedge clk)
	begin
		if (m_started)
		begin
			check_line(line, exp_line);
			check_frame(frame, exp_frame);
			check_int(result, exp_result, int_valid, exp_valid);
			if (hs_seen)
				hs_gap++;
			if (line.hsync_start === 1'b1)
			begin
				if (hs_seen && hs_gap != int'(SIM_H_PERIOD))
					fail_run($sformatf("[ERROR] %0t: hsync_start after %0d clocks, expected %0d",
						$time, hs_gap, SIM_H_PERIOD));
				hs_seen = 1'b1;
				hs_gap = 0;
			end
		end
	end

	task automatic build_table();
		rows[0].delay = 0;
		rows[1].delay = 5;
		rows[2].delay = NEVER;
		rows[3].delay = int'(SIM_INT_LEN) - 1; // last clock of the window
		rows[4].delay = int'($unsigned($random(seed)) % 32'd12);
		rows[5].delay = int'($unsigned($random(seed)) % 32'd12);
		for (int r = 0; r < ROWS; r++)
		begin
			rows[r].frame_no = r;
			rows[r].exp_res.taken  = (rows[r].delay < int'(SIM_INT_LEN));
			rows[r].exp_res.missed = (rows[r].delay >= int'(SIM_INT_LEN));
		end
	endtask

	task automatic apply_row(input int r);
		int n;
		n = 0;
		while (int_valid !== 1'b1 && n < 2 * FRAME_CLOCKS)
		begin
			@(negedge clk);
			n++;
		end
		if (int_valid !== 1'b1)
			fail_run($sformatf("interrupt request for table row %0d never came", r));
		if (m_frame_no != rows[r].frame_no)
			fail_run($sformatf("[ERROR] %0t: request in frame %0d, expected frame %0d",
				$time, m_frame_no, rows[r].frame_no));
		n = 0;
		while (int_valid === 1'b1 && n < int'(SIM_INT_LEN) + 4)
		begin
			if (n == rows[r].delay)
				int_ready = 1'b1; // sampled on the next rising edge
			@(negedge clk);
			n++;
		end
		if (int_valid === 1'b1)
			fail_run("interrupt request stayed high past its window");
		check_int(result, rows[r].exp_res, int_valid, 1'b0);
		int_ready = 1'b0;
	endtask

	initial
	begin
		int n;
		int_ready = 1'b0;
		build_table();
		n = 0;
		while (!m_active && n < 10)
		begin
			@(negedge clk);
			n++;
		end
		if (!m_active)
			fail_run("reset was never released");
		for (int r = 0; r < ROWS; r++)
			apply_row(r);
		$display("TEST PASSED");
		$finish;
	end

endmodule

/* test/video_sync_sva.sv */
`timescale 1ns/100ps

module video_sync_sva (
	input logic clk,
	input logic reset,
	input video_timing_pkg::frame_strobe_t frame
);

	// vertical sync lives inside vertical blank
	vsync_in_vblank: assert property (@(posedge clk) disable iff (reset)
		frame.vsync |-> frame.vblank)
		else $error("vsync high outside vblank");

	// frame interrupt is a single clock pulse
	int_start_pulse: assert property (@(posedge clk) disable iff (reset)
		frame.int_start |=> !frame.int_start)
		else $error("int_start held longer than one clock");

	// picture and blank never overlap
	vpix_not_blank: assert property (@(posedge clk) disable iff (reset)
		!(frame.vpix && frame.vblank))
		else $error("vpix and vblank high together");

endmodule

bind vsync_gen video_sync_sva u_vsync_sva (.clk(clk), .reset(reset), .frame(frame));

/* test/clock_gen.sv */
`timescale 1ns/100ps

module clock_gen #(
	parameter int half_period  = 5, // 10 ns clock
	parameter int reset_cycles = 2
) (
	output logic clk,
	output logic reset // synchronous, active high
);

	initial
	begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	// hold reset over the first rising edges, release on a falling edge
	initial
	begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

/* design/video_sync_top.sv */
`timescale 1ns/100ps

module video_sync_top #(
	// horizontal, in clocks
	parameter logic [15:0] h_period      = video_timing_pkg::H_PERIOD,
	parameter logic [15:0] hsync_beg     = video_timing_pkg::HSYNC_BEG,
	parameter logic [15:0] hsync_end     = video_timing_pkg::HSYNC_END,
	parameter logic [15:0] hblnk_end     = video_timing_pkg::HBLNK_END,
	parameter logic [15:0] hint_beg      = video_timing_pkg::HINT_BEG,
	// vertical, in lines
	parameter logic [15:0] v_period      = video_timing_pkg::V_PERIOD,
	parameter logic [15:0] vblnk_end     = video_timing_pkg::VBLNK_END,
	parameter logic [15:0] vsync_beg     = video_timing_pkg::VSYNC_BEG,
	parameter logic [15:0] vsync_end     = video_timing_pkg::VSYNC_END,
	parameter logic [15:0] vpix_beg      = video_timing_pkg::VPIX_BEG,
	parameter logic [15:0] vpix_end      = video_timing_pkg::VPIX_END,
	parameter logic [15:0] int_line      = video_timing_pkg::INT_LINE,
	parameter logic [15:0] s_reload_line = video_timing_pkg::S_RELOAD_LINE,
	parameter logic [15:0] int_len       = video_int_pkg::INT_LEN
) (
	input  logic clk,
	input  logic reset,
	output video_timing_pkg::line_strobe_t  line,
	output video_timing_pkg::frame_strobe_t frame,
	output logic int_valid,
	input  logic int_ready,
	output video_int_pkg::int_result_t result
);

	// line timing, also feeds the vertical counter
	hsync_gen #(
		.h_period(h_period), .hsync_beg(hsync_beg), .hsync_end(hsync_end),
		.hblnk_end(hblnk_end), .hint_beg(hint_beg)
	) u_hsync (.clk(clk), .reset(reset), .line(line));

	// frame timing, one register stage after the line strobes
	vsync_gen #(
		.v_period(v_period), .vblnk_end(vblnk_end), .vsync_beg(vsync_beg),
		.vsync_end(vsync_end), .vpix_beg(vpix_beg), .vpix_end(vpix_end),
		.int_line(int_line), .s_reload_line(s_reload_line)
	) u_vsync (.clk(clk), .reset(reset), .line(line), .frame(frame));

	// CPU interrupt request with timeout
	int_ctrl #(.int_len(int_len)) u_int (
		.clk(clk), .reset(reset), .frame(frame),
		.int_valid(int_valid), .int_ready(int_ready), .result(result)
	);

endmodule

/* design/int_ctrl.sv */
`timescale 1ns/100ps

module int_ctrl #(
	parameter logic [15:0] int_len = video_int_pkg::INT_LEN // window in clocks
) (
	input  logic clk,
	input  logic reset,
	input  video_timing_pkg::frame_strobe_t frame, // only int_start used
	output logic int_valid,  // INT request to the CPU
	input  logic int_ready,  // CPU acknowledges
	output video_int_pkg::int_result_t result
);

	import video_int_pkg::*;

	int_state_e  state;
	logic [15:0] win_cnt; // clocks spent pending, 0 .. int_len-1
	logic        transfer; // ready sampled while valid
	logic        expire;   // last window clock without ready

	assign int_valid = (state == INT_PENDING); // held for whole window
	assign transfer  = int_valid & int_ready;
	assign expire    = int_valid & ~int_ready & (win_cnt == int_len - 16'd1);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state   <= INT_IDLE;
			win_cnt <= 16'd0;
			result  <= '0;
		end
		else
		begin
			// outcome pulses land in the cycle valid drops
			result.taken  <= transfer;
			result.missed <= expire;

			case (state)
				INT_IDLE:
				begin
					if (frame.int_start)
					begin
						state   <= INT_PENDING; // valid rises next clock
						win_cnt <= 16'd0;
					end
				end
				INT_PENDING:
				begin
					// further int_start pulses are ignored here
					if (transfer || expire)
						state <= INT_IDLE;
					else
						win_cnt <= win_cnt + 16'd1;
				end
				default: state <= INT_IDLE;
			endcase
		end
	end

endmodule

/* design/vsync_gen.sv */
`timescale 1ns/100ps

module vsync_gen #(
	parameter logic [15:0] v_period      = video_timing_pkg::V_PERIOD,
	parameter logic [15:0] vblnk_end     = video_timing_pkg::VBLNK_END,
	parameter logic [15:0] vsync_beg     = video_timing_pkg::VSYNC_BEG,
	parameter logic [15:0] vsync_end     = video_timing_pkg::VSYNC_END,
	parameter logic [15:0] vpix_beg      = video_timing_pkg::VPIX_BEG,
	parameter logic [15:0] vpix_end      = video_timing_pkg::VPIX_END,
	parameter logic [15:0] int_line      = video_timing_pkg::INT_LINE,
	parameter logic [15:0] s_reload_line = video_timing_pkg::S_RELOAD_LINE
) (
	input  logic clk,
	input  logic reset,
	input  video_timing_pkg::line_strobe_t  line,  // from hsync_gen
	output video_timing_pkg::frame_strobe_t frame  // registered frame markers
);

	import video_timing_pkg::*;

	localparam logic [15:0] VBLNK_BEG = 16'd0; // blank starts at top of count

	logic [15:0] vcount; // current line, advances on hsync_start
	frame_strobe_t frame_next;

	// line counter, stepped once per line
	always_ff @(posedge clk)
	begin
		if (reset)
			vcount <= 16'd0;
		else if (line.hsync_start)
		begin
			if (vcount == v_period - 16'd1)
				vcount <= 16'd0; // new frame
			else
				vcount <= vcount + 16'd1;
		end
	end

	// all compares use vcount before its update, same clock as the strobe
	always_comb
	begin
		frame_next = frame; // levels hold between their update points

		if (line.hsync_start)
		begin
			// vertical blank window
			if (vcount == VBLNK_BEG)
				frame_next.vblank = 1'b1;
			else if (vcount == vblnk_end)
				frame_next.vblank = 1'b0;

			// picture window, changes with hsync edge
			if (vcount == vpix_beg)
				frame_next.vpix = 1'b1;
			else if (vcount == vpix_end)
				frame_next.vpix = 1'b0;
		end

		// vsync starts on hsync_start but ends on line_start,
		// so every hsync edge inside it is kept
		if (line.hsync_start && (vcount == vsync_beg))
			frame_next.vsync = 1'b1;
		else if (line.line_start && (vcount == vsync_end))
			frame_next.vsync = 1'b0;

		// preload markers, resampled at each line start
		if (line.line_start)
		begin
			frame_next.pre_vline = (vcount == vblnk_end);
			frame_next.s_reload  = (vcount == s_reload_line);
		end

		// interrupt column on the interrupt line only
		frame_next.int_start = line.hint_start && (vcount == int_line);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			frame <= '0;
		else
			frame <= frame_next; // second register stage after hcount
	end

endmodule

/* design/hsync_gen.sv */
`timescale 1ns/100ps

module hsync_gen #(
	parameter logic [15:0] h_period  = video_timing_pkg::H_PERIOD,
	parameter logic [15:0] hsync_beg = video_timing_pkg::HSYNC_BEG,
	parameter logic [15:0] hsync_end = video_timing_pkg::HSYNC_END,
	parameter logic [15:0] hblnk_end = video_timing_pkg::HBLNK_END,
	parameter logic [15:0] hint_beg  = video_timing_pkg::HINT_BEG
) (
	input  logic clk,
	input  logic reset,
	output video_timing_pkg::line_strobe_t line // all fields registered
);

	import video_timing_pkg::*;

	logic [15:0] hcount; // clock position within the line
	line_strobe_t line_next; // decode of hcount, loaded next clock

	// free-running line counter, 0 .. h_period-1
	always_ff @(posedge clk)
	begin
		if (reset)
			hcount <= 16'd0;
		else if (hcount == h_period - 16'd1)
			hcount <= 16'd0; // wrap to next line
		else
			hcount <= hcount + 16'd1;
	end

	// decode counter into strobes and levels
	always_comb
	begin
		line_next = line; // blank and sync levels hold unless changed below

		// single-clock pulses, one cycle behind the matching count
		line_next.hsync_start = (hcount == hsync_beg);
		line_next.line_start  = (hcount == hsync_end);
		line_next.hint_start  = (hcount == hint_beg);

		// blank opens at column 0
		if (hcount == 16'd0)
			line_next.hblank = 1'b1;
		else if (hcount == hblnk_end)
			line_next.hblank = 1'b0; // visible part begins

		// sync level tracks the two pulses exactly
		if (hcount == hsync_beg)
			line_next.hsync = 1'b1; // rises with hsync_start
		else if (hcount == hsync_end)
			line_next.hsync = 1'b0; // falls with line_start
	end

	// output register stage
	always_ff @(posedge clk)
	begin
		if (reset)
			line <= '0; // everything low out of reset
		else
			line <= line_next;
	end

endmodule

/* design/video_int_pkg.sv */
package video_int_pkg;

	// default INT window, a Z80 must sample INT within this many clocks
	localparam logic [15:0] INT_LEN = 16'd32;

	// request controller states
	typedef enum logic {
		INT_IDLE    = 1'b0, // no request outstanding
		INT_PENDING = 1'b1  // int_valid held, window running
	} int_state_e;

	// outcome of one request, each bit a single clock pulse
	typedef struct packed {
		logic taken;  // ready seen inside window
		logic missed; // window ran out
	} int_result_t;

endpackage

/* design/video_timing_pkg.sv */
package video_timing_pkg;

	// horizontal raster, counted in pixel clocks
	localparam logic [15:0] H_PERIOD  = 16'd448; // clocks per line
	localparam logic [15:0] HSYNC_BEG = 16'd10;  // hsync rises here
	localparam logic [15:0] HSYNC_END = 16'd43;  // hsync falls, line starts
	localparam logic [15:0] HBLNK_END = 16'd88;  // end of horizontal blank
	localparam logic [15:0] HINT_BEG  = 16'd2;   // column where INT may begin

	// vertical raster, counted in lines
	localparam logic [15:0] V_PERIOD  = 16'd320; // lines per frame
	localparam logic [15:0] VBLNK_END = 16'd32;
	localparam logic [15:0] VSYNC_BEG = 16'd8;
	localparam logic [15:0] VSYNC_END = 16'd11;
	localparam logic [15:0] VPIX_BEG  = 16'd80;  // first line of picture
	localparam logic [15:0] VPIX_END  = 16'd272; // first border line after picture
	localparam logic [15:0] INT_LINE  = 16'd0;   // frame INT fires on this line
	localparam logic [15:0] S_RELOAD_LINE = VBLNK_END + 16'd102; // mid-frame preload

	// per-line strobes from the horizontal counter
	typedef struct packed {
		logic hsync_start; // first clock of hsync
		logic line_start;  // clock where hsync ends
		logic hint_start;  // interrupt column
		logic hblank;      // level
		logic hsync;       // level
	} line_strobe_t;

	// per-frame strobes from the vertical counter
	typedef struct packed {
		logic vblank;
		logic vsync;
		logic vpix;      // picture lines, not border
		logic pre_vline; // line right after vblank
		logic s_reload;  // preload marker
		logic int_start; // one-clock pulse, start of Z80 INT
	} frame_strobe_t;

endpackage
